/* common/zx_params.svh */
// Fixed numbers of the Spectrum memory map and I/O decode
// Included by the blocks that build addresses or read data

`ifndef ZX_PARAMS_SVH
`define ZX_PARAMS_SVH

// ====================
// I/O ports
// ====================

// Kempston joystick, low six address bits
`define ZX_PORT_KEMPSTON 6'h1F

// Value seen on a read that nothing answers
`define ZX_IDLE_DATA 8'hFF

// ====================
// Memory map
// ====================

// Banks fixed at 4000 and 8000 in normal paging
`define ZX_BANK_SCREEN 3'd5
`define ZX_BANK_FIXED 3'd2

// Flat 16K slot of ROM 0
// Slots 0..7 hold RAM banks 0..7, ROMs follow
`define ZX_ROM_BASE 5'd16

`endif

/* common/zx_pkg.sv */
// Types shared by the bus controller blocks
// Referenced by scoped name, never imported

package zx_pkg;

	typedef logic [7:0]  byte_t;     // CPU data byte
	typedef logic [15:0] bus_addr_t; // Z80 address
	typedef logic [18:0] mem_addr_t; // 5-bit slot, 14-bit offset
	typedef logic [2:0]  bank_t;     // RAM bank number

	// Bit 0 right, 1 left, 2 down, 3 up, 4 fire
	typedef logic [4:0] joy_t;

	// Machine model, picked up while reset is held
	typedef enum logic [1:0] {
		MODEL_48    = 2'd0,
		MODEL_128   = 2'd1,
		MODEL_PLUS3 = 2'd2
	} model_t;

	typedef enum logic {
		JOY_KEMPSTON  = 1'b0,
		JOY_SINCLAIR1 = 1'b1
	} joy_mode_t;

	// Paging registers as seen by the rest of the design
	typedef struct packed {
		byte_t  reg_7ffd; // Bank, screen, ROM, lock
		byte_t  reg_1ffd; // Special mode, ROM high bit
		model_t model;
	} page_state_t;

endpackage

/* common/cpu_bus_if.sv */
// Z80 bus as seen by the controller blocks
// Top level drives it from the CPU pins

`timescale 1ns/1ps

interface cpu_bus_if;

	zx_pkg::bus_addr_t addr;
	zx_pkg::byte_t     dout;   // CPU write data
	logic              mreq_n;
	logic              iorq_n;
	logic              rd_n;
	logic              wr_n;
	logic              m1_n;

	// I/O write decode
	modport decoder (input addr, iorq_n, wr_n, m1_n);

	// Memory mapping and read data selection
	modport mapper (input addr, mreq_n, iorq_n, rd_n, wr_n, m1_n);

endinterface

/* logic/bus_decoder.sv */
// Turns Z80 I/O write cycles into single-clock write pulses
// for the 7FFD, 1FFD and FE ports

`timescale 1ns/1ps

module bus_decoder (
	input  logic                clk_sys,
	input  logic                reset,
	cpu_bus_if.decoder          bus,
	input  zx_pkg::page_state_t page_state,
	output logic                wr_7ffd,
	output logic                wr_1ffd,
	output logic                wr_ula
);

	logic io_wr;
	logic io_wr_q;
	logic io_wr_rise;
	logic paging_locked;
	logic sel_7ffd;
	logic sel_1ffd;
	logic sel_ula;
	logic is_plus3;

	assign io_wr = ~bus.iorq_n & ~bus.wr_n & bus.m1_n; // M1 high excludes INT ack

	always_ff @(posedge clk_sys) begin
		if (reset)
			io_wr_q <= 1'b0;
		else
			io_wr_q <= io_wr;
	end

	assign io_wr_rise = io_wr & ~io_wr_q;

	// ====================
	// Port select
	// ====================

	assign is_plus3      = (page_state.model == zx_pkg::MODEL_PLUS3);
	assign paging_locked = (page_state.model == zx_pkg::MODEL_48) | page_state.reg_7ffd[5];

	// +3 decodes A14 as well, to leave room for 1FFD
	assign sel_7ffd = ~bus.addr[15] & ~bus.addr[1] & (bus.addr[14] | ~is_plus3)
		& ~paging_locked;

	assign sel_1ffd = ~bus.addr[15] & ~bus.addr[14] & ~bus.addr[13] & bus.addr[12]
		& ~bus.addr[1] & is_plus3 & ~paging_locked;

	// ULA answers on any even address
	assign sel_ula = ~bus.addr[0];

	assign wr_7ffd = io_wr_rise & sel_7ffd;
	assign wr_1ffd = io_wr_rise & sel_1ffd;
	assign wr_ula  = io_wr_rise & sel_ula;

	// One port per write cycle
	a_one_pulse: assert property (
		@(posedge clk_sys) disable iff (reset)
		$onehot0({wr_7ffd, wr_1ffd, wr_ula})
	);

endmodule

/* paging/page_regs.sv */
// 128K and +3 paging registers plus the machine model
// Model is sampled while reset is held, registers load on decoder pulses

`timescale 1ns/1ps

module page_regs (
	input  logic                clk_sys,
	input  logic                reset,
	input  zx_pkg::model_t      model,
	input  logic                wr_7ffd,
	input  logic                wr_1ffd,
	input  zx_pkg::byte_t       data,
	output zx_pkg::page_state_t page_state
);

	zx_pkg::byte_t  reg_7ffd;
	zx_pkg::byte_t  reg_1ffd;
	zx_pkg::model_t model_q;

	// ====================
	// 7FFD
	// ====================

	// Bits 2..0 bank at C000, 3 screen, 4 ROM, 5 lock
	always_ff @(posedge clk_sys) begin
		if (reset)
			reg_7ffd <= '0;
		else if (wr_7ffd)
			reg_7ffd <= data;
	end

	// ====================
	// 1FFD
	// ====================

	// Bit 0 special paging, 2..1 special set or ROM high bit
	always_ff @(posedge clk_sys) begin
		if (reset)
			reg_1ffd <= '0;
		else if (wr_1ffd)
			reg_1ffd <= data;
	end

	// Model only changes across a reset
	always_ff @(posedge clk_sys) begin
		if (reset)
			model_q <= model;
	end

	always_comb begin
		page_state.reg_7ffd = reg_7ffd;
		page_state.reg_1ffd = reg_1ffd;
		page_state.model    = model_q;
	end

	// Once locked, 7FFD holds until the next reset
	a_lock_holds: assert property (
		@(posedge clk_sys) disable iff (reset)
		reg_7ffd[5] |=> $stable(reg_7ffd)
	);

endmodule

/* paging/ram_mapper.sv */
// Maps the 64K CPU space onto flat 16K slots of RAM banks and ROMs
// Purely combinational, answers in the same cycle as the strobes

`timescale 1ns/1ps

`include "zx_params.svh"

module ram_mapper (
	cpu_bus_if.mapper           bus,
	input  zx_pkg::page_state_t page_state,
	output zx_pkg::mem_addr_t   ram_addr,
	output logic                ram_rd,
	output logic                ram_we
);

	logic [1:0]    seg;
	logic [1:0]    rom_num;
	logic [4:0]    rom_slot;
	logic [4:0]    slot;
	logic          special;
	zx_pkg::bank_t norm_bank;
	zx_pkg::bank_t spec_bank;

	assign seg     = bus.addr[15:14];
	assign special = (page_state.model == zx_pkg::MODEL_PLUS3) & page_state.reg_1ffd[0];

	// ====================
	// ROM select
	// ====================

	always_comb begin
		case (page_state.model)
			zx_pkg::MODEL_48:    rom_num = 2'd1;
			zx_pkg::MODEL_PLUS3: rom_num = {page_state.reg_1ffd[2], page_state.reg_7ffd[4]};
			default:             rom_num = {1'b0, page_state.reg_7ffd[4]};
		endcase
	end

	assign rom_slot = `ZX_ROM_BASE + {3'b000, rom_num};

	always_comb begin
		case (seg)
			2'd1:    norm_bank = `ZX_BANK_SCREEN;
			2'd2:    norm_bank = `ZX_BANK_FIXED;
			default: norm_bank = page_state.reg_7ffd[2:0]; // Also unused for segment 0
		endcase
	end

	// +3 all-RAM sets 0123, 4567, 4563, 4763
	always_comb begin
		case (page_state.reg_1ffd[2:1])
			2'd0:    spec_bank = {1'b0, seg};
			2'd1:    spec_bank = {1'b1, seg};
			2'd2:    spec_bank = (seg == 2'd3) ? 3'd3 : {1'b1, seg};
			default: spec_bank = (seg == 2'd1) ? 3'd7 : (seg == 2'd3) ? 3'd3 : {1'b1, seg};
		endcase
	end

	assign slot = special ? {2'b00, spec_bank} :
		(seg == 2'd0) ? rom_slot : {2'b00, norm_bank};

	assign ram_addr = {slot, bus.addr[13:0]};
	assign ram_rd   = ~bus.mreq_n & ~bus.rd_n;
	assign ram_we   = ~bus.mreq_n & ~bus.wr_n & (special | (seg != 2'd0)); // ROM is read only

	// Checked at the end of each write strobe
	a_no_rom_write: assert property (
		@(posedge bus.wr_n) ram_we |-> (ram_addr[18:14] < `ZX_ROM_BASE)
	);

endmodule

/* logic/ula_port.sv */
// ULA port FE output side: border colour, EAR and MIC
// Loads on the decoder's FE write pulse

`timescale 1ns/1ps

module ula_port (
	input  logic          clk_sys,
	input  logic          reset,
	input  logic          wr_ula,
	input  zx_pkg::byte_t data,
	output logic [2:0]    border_color,
	output logic          ear_out,
	output logic          mic_out
);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= 3'd0;
			ear_out      <= 1'b0;
			mic_out      <= 1'b0;
		end else if (wr_ula) begin
			border_color <= data[2:0];
			ear_out      <= data[4]; // Speaker
			mic_out      <= data[3]; // Tape out
		end
	end

endmodule

/* logic/port_read_mux.sv */
// CPU read data: memory, Kempston port or the FE keyboard row
// Sinclair I joystick shows up as keys 6..0 on the FE read

`timescale 1ns/1ps

`include "zx_params.svh"

module port_read_mux (
	cpu_bus_if.mapper          bus,
	input  zx_pkg::joy_mode_t  joy_mode,
	input  zx_pkg::joy_t       joystick,
	input  logic [4:0]         key_data, // Active low half-row
	input  logic               ear_in,
	input  zx_pkg::byte_t      ram_dout,
	output zx_pkg::byte_t      cpu_din
);

	logic       mem_rd;
	logic       io_rd;
	logic       kempston_sel;
	logic [4:0] sinclair_keys;
	logic [4:0] joy_kbd;

	assign mem_rd = ~bus.mreq_n & ~bus.rd_n;
	assign io_rd  = ~bus.iorq_n & ~bus.rd_n & bus.m1_n;

	assign kempston_sel = (bus.addr[5:0] == `ZX_PORT_KEMPSTON)
		& (joy_mode == zx_pkg::JOY_KEMPSTON);

	// ====================
	// Sinclair I mapping
	// ====================

	// Keys 6,7,8,9,0 are left, right, down, up, fire
	assign sinclair_keys = (joy_mode == zx_pkg::JOY_SINCLAIR1) ?
		{joystick[1], joystick[0], joystick[2], joystick[3], joystick[4]} : 5'b00000;

	// Only the 6..0 half-row, selected by A12 low
	assign joy_kbd = {5{bus.addr[12]}} | ~sinclair_keys;

	always_comb begin
		if (mem_rd)
			cpu_din = ram_dout;
		else if (io_rd & kempston_sel)
			cpu_din = {3'b000, joystick};
		else if (io_rd & ~bus.addr[0])
			cpu_din = {1'b1, ear_in, 1'b1, key_data & joy_kbd};
		else
			cpu_din = `ZX_IDLE_DATA; // Floating bus
	end

endmodule

/* logic/zx_bus_ctrl.sv */
// Spectrum CPU-side bus controller top level
// CPU pins in, paged memory strobes, ULA outputs and read data out

`timescale 1ns/1ps

module zx_bus_ctrl (
	input  logic               clk_sys,
	input  logic               reset,
	input  zx_pkg::model_t     model,
	input  zx_pkg::joy_mode_t  joy_mode,
	input  zx_pkg::bus_addr_t  addr,
	input  zx_pkg::byte_t      cpu_dout,
	input  logic               mreq_n,
	input  logic               iorq_n,
	input  logic               rd_n,
	input  logic               wr_n,
	input  logic               m1_n,
	input  zx_pkg::byte_t      ram_dout,
	input  zx_pkg::joy_t       joystick,
	input  logic [4:0]         key_data,
	input  logic               ear_in,
	output zx_pkg::byte_t      cpu_din,
	output zx_pkg::mem_addr_t  ram_addr,
	output logic               ram_rd,
	output logic               ram_we,
	output logic [2:0]         border_color,
	output logic               ear_out,
	output logic               mic_out
);

	zx_pkg::page_state_t page_state;
	logic                wr_7ffd;
	logic                wr_1ffd;
	logic                wr_ula;

	// ====================
	// CPU bus
	// ====================

	cpu_bus_if bus ();

	assign bus.addr   = addr;
	assign bus.dout   = cpu_dout;
	assign bus.mreq_n = mreq_n;
	assign bus.iorq_n = iorq_n;
	assign bus.rd_n   = rd_n;
	assign bus.wr_n   = wr_n;
	assign bus.m1_n   = m1_n;

	bus_decoder u_bus_decoder (.clk_sys(clk_sys), .reset(reset), .bus(bus.decoder),
		.page_state(page_state), .wr_7ffd(wr_7ffd), .wr_1ffd(wr_1ffd), .wr_ula(wr_ula));

	page_regs u_page_regs (.clk_sys(clk_sys), .reset(reset), .model(model),
		.wr_7ffd(wr_7ffd), .wr_1ffd(wr_1ffd), .data(bus.dout), .page_state(page_state));

	ram_mapper u_ram_mapper (.bus(bus.mapper), .page_state(page_state),
		.ram_addr(ram_addr), .ram_rd(ram_rd), .ram_we(ram_we));

	ula_port u_ula_port (.clk_sys(clk_sys), .reset(reset), .wr_ula(wr_ula),
		.data(bus.dout), .border_color(border_color), .ear_out(ear_out), .mic_out(mic_out));

	port_read_mux u_port_read_mux (.bus(bus.mapper), .joy_mode(joy_mode),
		.joystick(joystick), .key_data(key_data), .ear_in(ear_in), .ram_dout(ram_dout),
		.cpu_din(cpu_din));

endmodule

/* verif/tb_zx_bus_ctrl.sv */
// Directed testbench for the Spectrum bus controller
// Covers paging, ROM protection, the ULA port and the read path

`timescale 1ns/1ps

module tb_zx_bus_ctrl;

	localparam int NUM_TESTS    = 5;
	localparam int TIMEOUT_CLKS = NUM_TESTS * 200;

	logic              clk_sys;
	logic              reset;
	zx_pkg::model_t    model;
	zx_pkg::joy_mode_t joy_mode;
	zx_pkg::bus_addr_t addr;
	zx_pkg::byte_t     cpu_dout;
	logic              mreq_n, iorq_n, rd_n, wr_n, m1_n;
	zx_pkg::byte_t     ram_dout;
	zx_pkg::joy_t      joystick;
	logic [4:0]        key_data;
	logic              ear_in;
	zx_pkg::byte_t     cpu_din;
	zx_pkg::mem_addr_t ram_addr;
	logic              ram_rd, ram_we;
	logic [2:0]        border_color;
	logic              ear_out, mic_out;
	int                errors;

	zx_bus_ctrl DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ====================
	// Helpers
	// ====================

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
			errors++;
		end
	endtask

	// Banks of segments 0..3, one octal digit each, segment 0 on the left
	function automatic logic [11:0] special_bank_set(input logic [1:0] v);
		case (v)
			2'd0:    return 12'o0123;
			2'd1:    return 12'o4567;
			2'd2:    return 12'o4563;
			default: return 12'o4763;
		endcase
	endfunction

	task automatic apply_reset(input zx_pkg::model_t m);
		@(posedge clk_sys);
		model <= m;
		reset <= 1'b1;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	task automatic io_write(input zx_pkg::bus_addr_t a, input zx_pkg::byte_t d);
		@(posedge clk_sys);
		addr     <= a;
		cpu_dout <= d;
		iorq_n   <= 1'b0;
		wr_n     <= 1'b0;
		repeat (3) @(posedge clk_sys);
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
	endtask

	task automatic io_read(input zx_pkg::bus_addr_t a, output zx_pkg::byte_t d);
		@(posedge clk_sys);
		addr   <= a;
		iorq_n <= 1'b0;
		rd_n   <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		d = cpu_din; // Sampled mid-cycle
		@(posedge clk_sys);
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
	endtask

	task automatic mem_access(input zx_pkg::bus_addr_t a, input logic write,
		output zx_pkg::mem_addr_t ra, output logic we, output logic rd, output zx_pkg::byte_t d);
		@(posedge clk_sys);
		addr   <= a;
		mreq_n <= 1'b0;
		if (write)
			wr_n <= 1'b0;
		else
			rd_n <= 1'b0;
		@(negedge clk_sys);
		ra = ram_addr;
		we = ram_we;
		rd = ram_rd;
		d  = cpu_din;
		@(posedge clk_sys);
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
	endtask

	// Memory read, then slot and offset against the expected slot
	task automatic check_slot(input zx_pkg::bus_addr_t a, input logic [4:0] slot, input string name);
		zx_pkg::mem_addr_t ra;
		logic              we, rd;
		zx_pkg::byte_t     d;
		mem_access(a, 1'b0, ra, we, rd, d);
		check_value(name, ra[18:14], slot);
		check_value("ram_addr offset", ra[13:0], a[13:0]);
		check_value("ram_rd", rd, 1'b1);
	endtask

	// ====================
	// Tests
	// ====================

	task automatic test_reset_map();
		apply_reset(zx_pkg::MODEL_128);
		check_slot(16'h0000, 5'd16, "slot at 0000");
		check_slot(16'h4000, 5'd5, "slot at 4000");
		check_slot(16'h8000, 5'd2, "slot at 8000");
		check_slot(16'hC000, 5'd0, "slot at C000");
		check_value("ear_out", ear_out, 1'b0);
		check_value("mic_out", mic_out, 1'b0);
	endtask

	task automatic test_7ffd_lock();
		zx_pkg::byte_t d;
		zx_pkg::byte_t locked;
		zx_pkg::byte_t other;
		apply_reset(zx_pkg::MODEL_128);
		d = $urandom & 8'hDF;
		io_write(16'h7FFD, d);
		check_slot(16'hC000, {2'b00, d[2:0]}, "bank at C000");
		check_slot(16'h0000, 5'd16 + d[4], "ROM slot");
		locked = $urandom | 8'h20;
		other  = ~locked; // Differs in every bank and ROM bit
		io_write(16'h7FFD, locked);
		io_write(16'h7FFD, other);
		check_slot(16'hC000, {2'b00, locked[2:0]}, "locked bank at C000");
		check_slot(16'h0000, 5'd16 + locked[4], "locked ROM slot");
		apply_reset(zx_pkg::MODEL_128);
		io_write(16'h7FFD, other);
		check_slot(16'hC000, {2'b00, other[2:0]}, "bank after unlock");
	endtask

	task automatic test_plus3();
		logic [11:0]       set;
		zx_pkg::bus_addr_t a;
		zx_pkg::mem_addr_t ra;
		zx_pkg::byte_t     d;
		logic              we, rd;
		apply_reset(zx_pkg::MODEL_PLUS3);
		mem_access(16'h0123, 1'b1, ra, we, rd, d);
		check_value("ram_we at ROM", we, 1'b0);
		io_write(16'h1FFD, 8'h04);
		io_write(16'h7FFD, 8'h10);
		check_slot(16'h0000, 5'd19, "+3 ROM slot"); // ROM 3
		for (int v = 0; v < 4; v++) begin
			d = v * 2 + 1;
			io_write(16'h1FFD, d);
			set = special_bank_set(v[1:0]);
			for (int s = 0; s < 4; s++) begin
				a = s * 16'h4000;
				check_slot(a, {2'b00, set[(3 - s) * 3 +: 3]}, "special bank");
			end
			mem_access(16'h0000, 1'b1, ra, we, rd, d);
			check_value("ram_we in special mode", we, 1'b1);
		end
	endtask

	task automatic test_ula_48k();
		zx_pkg::byte_t d;
		apply_reset(zx_pkg::MODEL_128);
		d = $urandom;
		io_write(16'h00FE, d);
		@(negedge clk_sys);
		check_value("border_color", border_color, d[2:0]);
		check_value("ear_out", ear_out, d[4]);
		check_value("mic_out", mic_out, d[3]);
		apply_reset(zx_pkg::MODEL_48);
		io_write(16'h7FFD, ($urandom | 8'h07) & 8'hCF);
		check_slot(16'hC000, 5'd0, "48K bank at C000");
		check_slot(16'h0000, 5'd17, "48K ROM slot");
	endtask

	task automatic test_read_path();
		zx_pkg::byte_t     d;
		zx_pkg::byte_t     expected;
		zx_pkg::joy_t      j;
		zx_pkg::mem_addr_t ra;
		logic [4:0]        keys;
		logic [4:0]        pulled;
		logic              e;
		logic              we, rd;
		apply_reset(zx_pkg::MODEL_128);
		expected = $urandom;
		ram_dout <= expected;
		mem_access(16'h8123, 1'b0, ra, we, rd, d);
		check_value("cpu_din on memory read", d, expected);
		j = $urandom;
		joy_mode <= zx_pkg::JOY_KEMPSTON;
		joystick <= j;
		io_read(16'h001F, d);
		check_value("cpu_din on Kempston", d, {3'b000, j});
		j    = $urandom | 5'h10; // Fire held
		keys = $urandom | 5'h01; // Key 0 up so the pull shows
		e    = $urandom;
		joy_mode <= zx_pkg::JOY_SINCLAIR1;
		joystick <= j;
		key_data <= keys;
		ear_in   <= e;
		pulled = {j[1], j[0], j[2], j[3], j[4]}; // Left, right, down, up, fire
		io_read(16'hEFFE, d);
		check_value("cpu_din on FE with A12 low", d, {1'b1, e, 1'b1, keys & ~pulled});
		io_read(16'hFEFE, d);
		check_value("cpu_din on FE with A12 high", d, {1'b1, e, 1'b1, keys});
		io_read(16'h00FF, d);
		check_value("cpu_din on unmapped port", d, 8'hFF);
	endtask

	// ====================
	// Run and watchdog
	// ====================

	initial begin
		repeat (TIMEOUT_CLKS) @(posedge clk_sys);
		$display("Timeout: the tests did not finish within %0d clocks", TIMEOUT_CLKS);
		$display("Test failed");
		$finish;
	end

	initial begin
		errors   = 0;
		void'($urandom(32'h273a_18d1));
		reset    = 1'b1;
		model    = zx_pkg::MODEL_128;
		joy_mode = zx_pkg::JOY_KEMPSTON;
		addr     = '0;
		cpu_dout = '0;
		mreq_n   = 1'b1;
		iorq_n   = 1'b1;
		rd_n     = 1'b1;
		wr_n     = 1'b1;
		m1_n     = 1'b1;
		ram_dout = '0;
		joystick = '0;
		key_data = 5'h1F; // No key pressed
		ear_in   = 1'b0;
		test_reset_map();
		test_7ffd_lock();
		test_plus3();
		test_ula_48k();
		test_read_path();
		$display("Checks done, errors: %0d", errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* flist.f */
+incdir+common
common/zx_pkg.sv
common/cpu_bus_if.sv
logic/bus_decoder.sv
paging/page_regs.sv
paging/ram_mapper.sv
logic/ula_port.sv
logic/port_read_mux.sv
logic/zx_bus_ctrl.sv
verif/tb_zx_bus_ctrl.sv

/* Bender.yml */
package:
  name: zx_bus_ctrl

sources:
  - include_dirs:
      - common
    files:
      - common/zx_pkg.sv
      - common/cpu_bus_if.sv
      - logic/bus_decoder.sv
      - paging/page_regs.sv
      - paging/ram_mapper.sv
      - logic/ula_port.sv
      - logic/port_read_mux.sv
      - logic/zx_bus_ctrl.sv
  - target: test
    files:
      - verif/tb_zx_bus_ctrl.sv
